// File: verif/proc_ctrl_patterns.txt
# name inst next br_flag req_dly resp_dly alu_fn pc_sel pc_stage mem_type rf_wen rf_waddr
# dep(0 adjacent, 1 waits for writeback, 2 none) next_waddr next_writes
addu      00221821 00a64821 0 0 0 0 3 X 0 1 3 0 9 1
subu      00221823 00a64821 0 0 0 1 3 X 0 1 3 0 9 1
and       00221824 00a64821 0 0 0 2 3 X 0 1 3 0 9 1
or        00221825 00a64821 0 0 0 3 3 X 0 1 3 0 9 1
xor       00221826 00a64821 0 0 0 4 3 X 0 1 3 0 9 1
addiu     24230005 00a64821 0 0 0 0 3 X 0 1 3 0 9 1
ori       342300ff 00a64821 0 0 0 3 3 X 0 1 3 0 9 1
lui       3c031234 00a64821 0 0 0 5 3 X 0 1 3 0 9 1
raw_rs    00221821 00644821 0 0 0 0 3 X 0 1 3 1 9 1
raw_rt    00221821 00834821 0 0 0 0 3 X 0 1 3 1 9 1
raw_r0    24200005 00044821 0 0 0 0 3 X 0 1 0 0 9 1
beq_taken 10220004 00a64821 1 0 0 1 0 X 0 0 0 2 9 0
beq_fall  10220004 00a64821 0 0 0 1 3 X 0 0 0 0 9 1
bne_taken 14220004 00a64821 0 0 0 1 0 X 0 0 0 2 9 0
bne_fall  14220004 00a64821 1 0 0 1 3 X 0 0 0 0 9 1
j         08000010 00a64821 0 0 0 0 2 D 0 0 0 2 9 0
jr        00200008 00a64821 0 0 0 0 1 D 0 0 0 2 9 0
lw        8c230004 00a64821 0 3 2 0 3 X 1 1 3 0 9 1
lw_raw    8c230004 00644821 0 1 1 0 3 X 1 1 3 1 9 1
sw        ac220008 00a64821 0 2 0 0 3 X 2 0 0 0 9 1
addu_sw   00221821 ac220008 0 3 1 0 3 X 0 1 3 0 9 0

// File: proc_ctrl.f
+incdir+hdl
hdl/proc_ctrl_pkg.sv
hdl/stage_ctrl.sv
hdl/inst_decoder.sv
hdl/hazard_unit.sv
hdl/proc_ctrl.sv
verif/proc_ctrl_tb.sv

// File: Bender.yml
package:
  name: proc_ctrl

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/proc_ctrl_pkg.sv
      - hdl/stage_ctrl.sv
      - hdl/inst_decoder.sv
      - hdl/hazard_unit.sv
      - hdl/proc_ctrl.sv
  - target: test
    include_dirs:
      - hdl
    files:
      - verif/proc_ctrl_tb.sv

// File: verif/proc_ctrl_tb.sv
// Pipeline control unit testbench
// Replays pattern lines through a small fetch model and checks control outputs

`timescale 1ns/1ps
`include "proc_ctrl_params.svh"

module proc_ctrl_tb;
  import proc_ctrl_pkg::*;

  localparam int MAX_CYCLES = 80;

  logic clk;
  logic reset;
  dpath_status_t status;
  dpath_ctrl_t ctrl;
  logic imemreq_val, imemresp_val, imemresp_rdy, imemresp_drop;
  logic dmemreq_val, dmemreq_rdy, dmemresp_val, dmemresp_rdy;
  mem_type_e dmemreq_type;

  // Current pattern
  string p_name, p_stg, line;
  logic [`INST_W-1:0] p_inst, p_next;
  int p_flag, p_rdly, p_sdly, p_alu, p_pc, p_mem, p_wen, p_waddr, p_dep, p_nwaddr, p_nwb;

  int test_errors, passed, failed, fd, n_fields;
  logic timed_out;
  logic [`INST_W-1:0] words [0:3];  // 1 is the test word, 2 its follower, 3 a NOP
  int tag_f, tag_d, tag_x, tag_m, tag_w;
  int req_cnt, resp_cnt;

  proc_ctrl u_dut (
    .clk(clk), .reset(reset), .status(status), .ctrl(ctrl),
    .imemreq_val(imemreq_val), .imemresp_val(imemresp_val), .imemresp_rdy(imemresp_rdy),
    .imemresp_drop(imemresp_drop), .dmemreq_val(dmemreq_val), .dmemreq_type(dmemreq_type),
    .dmemreq_rdy(dmemreq_rdy), .dmemresp_val(dmemresp_val), .dmemresp_rdy(dmemresp_rdy)
  );

  always #20 clk = ~clk;

  task automatic check_alu_fn(alu_fn_e exp_v, alu_fn_e act_v);
    if (act_v !== exp_v) begin
      $display("** Error %s: alu_fn_X expected %0d, actual %0d", p_name, exp_v, act_v);
      test_errors++;
    end
  endtask

  task automatic check_pc_sel(pc_sel_e exp_v, pc_sel_e act_v);
    if (act_v !== exp_v) begin
      $display("** Error %s: pc_sel_F expected %0d, actual %0d", p_name, exp_v, act_v);
      test_errors++;
    end
  endtask

  task automatic check_mem_type(mem_type_e exp_v, mem_type_e act_v);
    if (act_v !== exp_v) begin
      $display("** Error %s: dmemreq_type expected %0d, actual %0d", p_name, exp_v, act_v);
      test_errors++;
    end
  endtask

  task automatic check_op1_sel(op1_sel_e exp_v, op1_sel_e act_v);
    if (act_v !== exp_v) begin
      $display("** Error %s: op1_sel_D expected %0d, actual %0d", p_name, exp_v, act_v);
      test_errors++;
    end
  endtask

  task automatic check_wb_sel(wb_sel_e exp_v, wb_sel_e act_v);
    if (act_v !== exp_v) begin
      $display("** Error %s: wb_sel_M expected %0d, actual %0d", p_name, exp_v, act_v);
      test_errors++;
    end
  endtask

  task automatic check_waddr(logic [`REG_ADDR_W-1:0] exp_v, logic [`REG_ADDR_W-1:0] act_v);
    if (act_v !== exp_v) begin
      $display("** Error %s: rf_waddr_W expected %0d, actual %0d", p_name, exp_v, act_v);
      test_errors++;
    end
  endtask

  task automatic check_bit(string what, logic exp_v, logic act_v);
    if (act_v !== exp_v) begin
      $display("** Error %s: %s expected %0b, actual %0b", p_name, what, exp_v, act_v);
      test_errors++;
    end
  endtask

  task automatic complain(string msg);
    $display("Failure in %s: %s", p_name, msg);
    test_errors++;
  endtask

  // Operand 1 source implied by the opcode
  function automatic op1_sel_e op1_for_word(logic [`INST_W-1:0] w);
    case (w[`OP_MSB:`OP_LSB])
      `OP_ADDIU, `OP_LW, `OP_SW: return op1_sext_imm;
      `OP_ORI, `OP_LUI:          return op1_zext_imm;
      default:                   return op1_rdat;
    endcase
  endfunction

  task automatic drive_inputs();
    status.inst_D       = words[tag_d];
    status.br_cond_eq_X = p_flag[0];
    dmemreq_rdy         = (req_cnt == 0);
    dmemresp_val        = (resp_cnt == 0);
  endtask

  task automatic run_test();
    int cyc;
    int fetch_idx;
    int drops;
    int nwb_seen;
    logic seen_w1;
    logic seen_x2;
    logic done;
    logic kill_f;
    logic br_kill;
    logic next_mem;
    logic wait_x;
    logic wait_m;
    logic hold_d;
    test_errors = 0;
    words[1] = p_inst;
    words[2] = p_next;
    {tag_f, tag_d, tag_x, tag_m, tag_w} = '0;
    fetch_idx = 1;
    drops = 0;
    nwb_seen = 0;
    seen_w1 = 1'b0;
    seen_x2 = 1'b0;
    done = 1'b0;
    next_mem = (p_next[`OP_MSB:`OP_LSB] == `OP_LW) || (p_next[`OP_MSB:`OP_LSB] == `OP_SW);
    req_cnt = p_rdly + ($urandom % 2);
    resp_cnt = p_sdly + ($urandom % 2);
    @(posedge clk);
    #2 reset = 1'b1;
    repeat (2) @(posedge clk);
    #2 reset = 1'b0;
    drive_inputs();
    for (cyc = 0; cyc < MAX_CYCLES && !done; cyc++) begin
      @(negedge clk);
      if (cyc == 0) begin
        check_bit("rf_wen_W after reset", 1'b0, ctrl.rf_wen_W);
        check_bit("dmemreq_val after reset", 1'b0, dmemreq_val);
        check_bit("dmemresp_rdy after reset", 1'b0, dmemresp_rdy);
      end

      // Expected hold of D and F from the memory waits and the pending write
      wait_x = ((tag_x == 1 && p_mem != 0) || (tag_x == 2 && next_mem)) && !dmemreq_rdy;
      wait_m = ((tag_m == 1 && p_mem != 0) || (tag_m == 2 && next_mem)) && !dmemresp_val;
      hold_d = wait_x || wait_m ||
               (p_dep == 1 && tag_d == 2 && (tag_x == 1 || tag_m == 1 || tag_w == 1));
      check_bit("imemreq_val", !hold_d, imemreq_val);
      check_bit("imemresp_rdy", !hold_d, imemresp_rdy);

      if (!ctrl.reg_en[`STG_W]) complain("W stage stopped retiring");
      if (wait_x && !wait_m && !ctrl.reg_en[`STG_M])
        complain("M stage stopped draining during a data request wait");
      if (tag_x == 1) begin
        check_alu_fn(alu_fn_e'(p_alu), ctrl.alu_fn_X);
        if (p_stg == "X") check_pc_sel(pc_sel_e'(p_pc), ctrl.pc_sel_F);
        if (p_mem != 0) begin
          check_bit("dmemreq_val", 1'b1, dmemreq_val);
          check_mem_type(mem_type_e'(p_mem), dmemreq_type);
        end
      end
      if (tag_d == 1 || tag_d == 2) check_op1_sel(op1_for_word(words[tag_d]), ctrl.op1_sel_D);
      if (tag_d == 1 && p_stg == "D") check_pc_sel(pc_sel_e'(p_pc), ctrl.pc_sel_F);
      if (tag_m == 1 && p_mem != 0) check_bit("dmemresp_rdy", 1'b1, dmemresp_rdy);
      if (tag_m == 1 && p_mem == 1) check_wb_sel(wb_mem, ctrl.wb_sel_M);
      if (tag_w == 1) begin
        seen_w1 = 1'b1;
        check_bit("rf_wen_W", p_wen[0], ctrl.rf_wen_W);
        if (p_wen != 0) check_waddr(p_waddr[`REG_ADDR_W-1:0], ctrl.rf_waddr_W);
      end
      if (tag_x == 2 && !seen_x2) begin
        seen_x2 = 1'b1;
        if (p_dep == 1 && !seen_w1) complain("dependent instruction reached X too early");
        if (p_dep == 0 && tag_m != 1) complain("independent instruction was held in D");
      end
      if (ctrl.rf_wen_W && ctrl.rf_waddr_W == p_nwaddr[`REG_ADDR_W-1:0]) nwb_seen++;
      if (imemresp_drop) drops++;
      if (dmemreq_val && !dmemreq_rdy && req_cnt > 0) req_cnt--;
      if (dmemresp_rdy && !dmemresp_val && resp_cnt > 0) resp_cnt--;

      // Stage model, advanced with the DUT register enables
      br_kill = (ctrl.pc_sel_F == pc_branch);
      kill_f  = (ctrl.pc_sel_F != pc_plus4);
      if (ctrl.reg_en[`STG_W]) tag_w = ctrl.reg_en[`STG_M] ? tag_m : 0;
      if (ctrl.reg_en[`STG_M]) tag_m = ctrl.reg_en[`STG_X] ? tag_x : 0;
      if (ctrl.reg_en[`STG_X]) tag_x = (ctrl.reg_en[`STG_D] && !br_kill) ? tag_d : 0;
      if (ctrl.reg_en[`STG_D]) tag_d = kill_f ? 0 : tag_f;
      if (ctrl.reg_en[`STG_F]) begin
        tag_f = fetch_idx;
        if (fetch_idx < 3) fetch_idx++;
      end
      done = seen_w1 && (tag_w == 3);
      @(posedge clk);
      #2 drive_inputs();
    end
    if (!done) begin
      $display("Timeout: test %s did not finish within %0d cycles", p_name, MAX_CYCLES);
      failed++;
      timed_out = 1'b1;
    end else begin
      check_bit("single imemresp_drop", (p_pc != 3), (drops == 1));
      if (p_pc == 3 && drops != 0) complain("imemresp_drop raised without a redirect");
      check_bit("follower writeback", p_nwb[0], (nwb_seen > 0));
      if (test_errors == 0) passed++;
      else failed++;
      $display("test %s %s (%0d errors)", p_name, (test_errors == 0) ? "ok" : "bad",
               test_errors);
    end
  endtask

  initial begin
    clk = 1'b0;
    reset = 1'b1;
    status = '0;
    imemresp_val = 1'b1;
    dmemreq_rdy = 1'b0;
    dmemresp_val = 1'b0;
    words[0] = '0;
    words[3] = '0;
    passed = 0;
    failed = 0;
    timed_out = 1'b0;
    void'($urandom(32'hb6f8));
    fd = $fopen("verif/proc_ctrl_patterns.txt", "r");
    if (fd == 0) begin
      $display("Could not open the pattern file");
      $display("FAIL: see errors above");
      $finish;
    end else begin
      while (!$feof(fd) && !timed_out) begin
        line = "";
        void'($fgets(line, fd));
        if (line.len() < 2 || line[0] == "#") continue;
        n_fields = $sscanf(line, "%s %h %h %d %d %d %d %d %s %d %d %d %d %d %d",
                           p_name, p_inst, p_next, p_flag, p_rdly, p_sdly, p_alu, p_pc,
                           p_stg, p_mem, p_wen, p_waddr, p_dep, p_nwaddr, p_nwb);
        if (n_fields != 15) begin
          $display("Pattern line could not be parsed: %s", line);
          failed++;
        end else begin
          run_test();
        end
      end
      $fclose(fd);
      $display("Tests: %0d passed, %0d failed", passed, failed);
      if (failed == 0 && passed > 0) begin
        $display("PASS: all tests");
      end else begin
        $display("FAIL: see errors above");
      end
      $finish;
    end
  end

endmodule

// File: hdl/proc_ctrl.sv
// Five-stage pipeline control unit
// Stage chain, decode, hazard stall, redirects and memory val/rdy handshakes

`timescale 1ns/1ps
`include "proc_ctrl_params.svh"

module proc_ctrl (
  input  logic                         clk,
  input  logic                         reset,
  input  proc_ctrl_pkg::dpath_status_t status,
  output proc_ctrl_pkg::dpath_ctrl_t   ctrl,
  output logic                         imemreq_val,
  input  logic                         imemresp_val,
  output logic                         imemresp_rdy,
  output logic                         imemresp_drop,
  output logic                         dmemreq_val,
  output proc_ctrl_pkg::mem_type_e     dmemreq_type,
  input  logic                         dmemreq_rdy,
  input  logic                         dmemresp_val,
  output logic                         dmemresp_rdy
);
  import proc_ctrl_pkg::*;

  logic [`NUM_STAGES-1:0] stall_src;    // Local stall per stage
  logic [`NUM_STAGES-1:0] squash_src;   // Local redirect per stage
  logic [`NUM_STAGES-1:0] reg_en;
  logic [`NUM_STAGES-1:0] stage_val;

  // Boundary i sits in front of stage i, the last one is past W
  logic [`NUM_STAGES:0]   link_val;
  logic [`NUM_STAGES:0]   link_stall;
  logic [`NUM_STAGES:0]   link_squash;

  ctrl_bundle_t           ctrl_D;
  op1_sel_e               op1_sel_D;
  logic                   rs_en_D;
  logic                   rt_en_D;
  logic [`REG_ADDR_W-1:0] rs_D;
  logic [`REG_ADDR_W-1:0] rt_D;
  logic                   stall_hazard_D;
  pc_sel_e                j_pc_sel_D;
  logic                   j_taken_D;

  ctrl_bundle_t [2:0]     bundle_d;     // Index 0 is X, 2 is W
  ctrl_bundle_t [2:0]     bundle_q;
  ctrl_bundle_t           bundle_X;
  ctrl_bundle_t           bundle_M;
  ctrl_bundle_t           bundle_W;
  logic                   live_X;
  logic                   br_taken_X;
  logic                   mem_X;
  logic                   mem_M;

  // ------------------------------------------------------------------------
  // Stage chain
  // ------------------------------------------------------------------------

  assign link_val[`STG_F]         = 1'b1;  // F fetches every cycle it can
  assign link_stall[`NUM_STAGES]  = 1'b0;
  assign link_squash[`NUM_STAGES] = 1'b0;

  for (genvar i = 0; i < `NUM_STAGES; i++) begin : g_stage
    stage_link_t link_in;

    assign link_in = '{val: link_val[i], stall: link_stall[i], squash: link_squash[i]};

    stage_ctrl u_stage_ctrl (
      .clk         (clk),
      .reset       (reset),
      .prev        (link_in),
      .stall_self  (stall_src[i]),
      .squash_self (squash_src[i]),
      .next_stall  (link_stall[i+1]),
      .next_squash (link_squash[i+1]),
      .reg_en      (reg_en[i]),
      .val         (stage_val[i]),
      .next_val    (link_val[i+1]),
      .prev_stall  (link_stall[i]),
      .prev_squash (link_squash[i])
    );
  end

  always_comb begin
    stall_src              = '0;
    squash_src             = '0;
    stall_src[`STG_F]      = !imemresp_val && !imemresp_drop;
    stall_src[`STG_D]      = stall_hazard_D;
    stall_src[`STG_X]      = mem_X && !dmemreq_rdy;   // Request not yet accepted
    stall_src[`STG_M]      = mem_M && !dmemresp_val;  // Response still outstanding
    squash_src[`STG_D]     = j_taken_D;
    squash_src[`STG_X]     = br_taken_X;
  end

  // ------------------------------------------------------------------------
  // D stage: decode, hazards, jumps
  // ------------------------------------------------------------------------

  assign rs_D = status.inst_D[`RS_MSB:`RS_LSB];
  assign rt_D = status.inst_D[`RT_MSB:`RT_LSB];

  inst_decoder u_inst_decoder (
    .inst    (status.inst_D),
    .ctrl    (ctrl_D),
    .op1_sel (op1_sel_D),
    .rs_en   (rs_en_D),
    .rt_en   (rt_en_D)
  );

  hazard_unit u_hazard_unit (
    .rs    (rs_D),
    .rt    (rt_D),
    .rs_en (rs_en_D),
    .rt_en (rt_en_D),
    .val_D (stage_val[`STG_D]),
    .dst_X (bundle_X),
    .dst_M (bundle_M),
    .dst_W (bundle_W),
    .val_X (stage_val[`STG_X]),
    .val_M (stage_val[`STG_M]),
    .val_W (stage_val[`STG_W]),
    .stall (stall_hazard_D)
  );

  always_comb begin
    j_pc_sel_D = pc_plus4;
    if (stage_val[`STG_D]) begin
      case (ctrl_D.j_type)
        j_imm:   j_pc_sel_D = pc_jump;
        j_reg:   j_pc_sel_D = pc_reg;
        default: j_pc_sel_D = pc_plus4;
      endcase
    end
  end

  assign j_taken_D = (j_pc_sel_D != pc_plus4);

  // ------------------------------------------------------------------------
  // X, M and W control registers
  // ------------------------------------------------------------------------

  assign bundle_d = {bundle_q[1], bundle_q[0], ctrl_D};

  always_ff @(posedge clk) begin
    for (int s = 0; s < 3; s++) begin
      if (reset) begin
        bundle_q[s].rf_wen <= 1'b0;
      end else if (reg_en[`STG_X + s]) begin
        bundle_q[s] <= bundle_d[s];
      end
    end
  end

  assign bundle_X = bundle_q[0];
  assign bundle_M = bundle_q[1];
  assign bundle_W = bundle_q[2];

  // Branch resolution, unknown words act as bubbles
  assign live_X = stage_val[`STG_X] && bundle_X.inst_val;

  always_comb begin
    br_taken_X = 1'b0;
    if (live_X) begin
      case (bundle_X.br_type)
        br_eq:   br_taken_X = status.br_cond_eq_X;
        br_ne:   br_taken_X = !status.br_cond_eq_X;
        default: br_taken_X = 1'b0;
      endcase
    end
  end

  // ------------------------------------------------------------------------
  // Memory handshakes and datapath control
  // ------------------------------------------------------------------------

  assign imemreq_val   = !link_stall[`STG_F];
  assign imemresp_rdy  = !link_stall[`STG_D];
  assign imemresp_drop = link_squash[`STG_D] && !link_stall[`STG_D];  // Wrong-path fetch

  assign mem_X        = live_X && (bundle_X.mem_type != mem_none);
  assign dmemreq_val  = mem_X && !link_stall[`STG_M];
  assign dmemreq_type = bundle_X.mem_type;
  assign mem_M        = stage_val[`STG_M] && (bundle_M.mem_type != mem_none);
  assign dmemresp_rdy = mem_M && !link_stall[`STG_W];

  always_comb begin
    ctrl.pc_sel_F   = br_taken_X ? pc_branch : j_pc_sel_D;  // Branch beats jump
    ctrl.reg_en     = reg_en;
    ctrl.op1_sel_D  = op1_sel_D;
    ctrl.alu_fn_X   = bundle_X.alu_fn;
    ctrl.wb_sel_M   = bundle_M.wb_sel;
    ctrl.rf_wen_W   = link_val[`NUM_STAGES] && bundle_W.rf_wen;  // Retiring instruction
    ctrl.rf_waddr_W = bundle_W.rf_waddr;
  end

endmodule

// File: hdl/hazard_unit.sv
// Read-after-write hazard detection
// Stalls D while a valid X, M or W instruction still has to write a D source

`timescale 1ns/1ps
`include "proc_ctrl_params.svh"

module hazard_unit (
  input  logic [`REG_ADDR_W-1:0]      rs,
  input  logic [`REG_ADDR_W-1:0]      rt,
  input  logic                        rs_en,
  input  logic                        rt_en,
  input  logic                        val_D,
  input  proc_ctrl_pkg::ctrl_bundle_t dst_X,
  input  proc_ctrl_pkg::ctrl_bundle_t dst_M,
  input  proc_ctrl_pkg::ctrl_bundle_t dst_W,
  input  logic                        val_X,
  input  logic                        val_M,
  input  logic                        val_W,
  output logic                        stall
);
  import proc_ctrl_pkg::*;

  logic rs_hit;
  logic rt_hit;

  // Write to src still pending in one later stage, r0 never conflicts
  function automatic logic pending(
    input ctrl_bundle_t           dst,
    input logic                   dst_val,
    input logic [`REG_ADDR_W-1:0] src
  );
    return dst_val && dst.rf_wen && (dst.rf_waddr == src) && (src != '0);
  endfunction

  assign rs_hit = rs_en && (pending(dst_X, val_X, rs) || pending(dst_M, val_M, rs) ||
                            pending(dst_W, val_W, rs));
  assign rt_hit = rt_en && (pending(dst_X, val_X, rt) || pending(dst_M, val_M, rt) ||
                            pending(dst_W, val_W, rt));

  assign stall = val_D && (rs_hit || rt_hit);  // No bypass, wait for writeback

endmodule

// File: hdl/inst_decoder.sv
// Instruction decoder
// Control table from the D-stage instruction word to its control bundle

`timescale 1ns/1ps
`include "proc_ctrl_params.svh"

module inst_decoder (
  input  logic [`INST_W-1:0]          inst,
  output proc_ctrl_pkg::ctrl_bundle_t ctrl,
  output proc_ctrl_pkg::op1_sel_e     op1_sel,
  output logic                        rs_en,
  output logic                        rt_en
);
  import proc_ctrl_pkg::*;

  typedef struct packed {
    ctrl_bundle_t bundle;
    op1_sel_e     op1_sel;
    logic         rs_en;
    logic         rt_en;
  } dec_row_t;

  localparam logic y = 1'b1;
  localparam logic n = 1'b0;
  localparam logic [`REG_ADDR_W-1:0] r0 = '0;  // No write

  logic [`REG_ADDR_W-1:0] rt;
  logic [`REG_ADDR_W-1:0] rd;
  dec_row_t               row;

  function automatic dec_row_t cs(
    input logic                   val,
    input br_type_e               br,
    input j_type_e                j,
    input op1_sel_e               op1,
    input logic                   rs_rd,
    input logic                   rt_rd,
    input alu_fn_e                alu,
    input mem_type_e              mem,
    input wb_sel_e                wb,
    input logic                   wen,
    input logic [`REG_ADDR_W-1:0] waddr
  );
    dec_row_t r;
    r.bundle.inst_val = val;
    r.bundle.br_type  = br;
    r.bundle.j_type   = j;
    r.bundle.alu_fn   = alu;
    r.bundle.mem_type = mem;
    r.bundle.wb_sel   = wb;
    r.bundle.rf_wen   = wen;
    r.bundle.rf_waddr = waddr;
    r.op1_sel         = op1;
    r.rs_en           = rs_rd;
    r.rt_en           = rt_rd;
    return r;
  endfunction

  assign rt = inst[`RT_MSB:`RT_LSB];
  assign rd = inst[`RD_MSB:`RD_LSB];

  // Columns: val br j op1 rs_en rt_en alu mem wb wen waddr
  always_comb begin
    casez (inst)
      {`INST_W{1'b0}}:  // NOP
        row = cs(y, br_none, j_none, op1_rdat, n, n, alu_add, mem_none, wb_alu, n, r0);
      {`OP_SPECIAL, 20'b?, `FUNC_ADDU}:
        row = cs(y, br_none, j_none, op1_rdat, y, y, alu_add, mem_none, wb_alu, y, rd);
      {`OP_SPECIAL, 20'b?, `FUNC_SUBU}:
        row = cs(y, br_none, j_none, op1_rdat, y, y, alu_sub, mem_none, wb_alu, y, rd);
      {`OP_SPECIAL, 20'b?, `FUNC_AND}:
        row = cs(y, br_none, j_none, op1_rdat, y, y, alu_and, mem_none, wb_alu, y, rd);
      {`OP_SPECIAL, 20'b?, `FUNC_OR}:
        row = cs(y, br_none, j_none, op1_rdat, y, y, alu_or, mem_none, wb_alu, y, rd);
      {`OP_SPECIAL, 20'b?, `FUNC_XOR}:
        row = cs(y, br_none, j_none, op1_rdat, y, y, alu_xor, mem_none, wb_alu, y, rd);
      {`OP_ADDIU, 26'b?}:
        row = cs(y, br_none, j_none, op1_sext_imm, y, n, alu_add, mem_none, wb_alu, y, rt);
      {`OP_ORI, 26'b?}:
        row = cs(y, br_none, j_none, op1_zext_imm, y, n, alu_or, mem_none, wb_alu, y, rt);
      {`OP_LUI, 26'b?}:
        row = cs(y, br_none, j_none, op1_zext_imm, n, n, alu_lui, mem_none, wb_alu, y, rt);
      {`OP_BEQ, 26'b?}:  // Equality flag comes from the datapath
        row = cs(y, br_eq, j_none, op1_rdat, y, y, alu_sub, mem_none, wb_alu, n, r0);
      {`OP_BNE, 26'b?}:
        row = cs(y, br_ne, j_none, op1_rdat, y, y, alu_sub, mem_none, wb_alu, n, r0);
      {`OP_J, 26'b?}:
        row = cs(y, br_none, j_imm, op1_rdat, n, n, alu_add, mem_none, wb_alu, n, r0);
      {`OP_SPECIAL, 20'b?, `FUNC_JR}:
        row = cs(y, br_none, j_reg, op1_rdat, y, n, alu_add, mem_none, wb_alu, n, r0);
      {`OP_LW, 26'b?}:
        row = cs(y, br_none, j_none, op1_sext_imm, y, n, alu_add, mem_load, wb_mem, y, rt);
      {`OP_SW, 26'b?}:  // rt holds the store data
        row = cs(y, br_none, j_none, op1_sext_imm, y, y, alu_add, mem_store, wb_alu, n, r0);
      default:
        row = cs(n, br_none, j_none, op1_rdat, n, n, alu_add, mem_none, wb_alu, n, r0);
    endcase
  end

  assign ctrl    = row.bundle;
  assign op1_sel = row.op1_sel;
  assign rs_en   = row.rs_en;
  assign rt_en   = row.rt_en;

endmodule

// File: hdl/stage_ctrl.sv
// Pipeline stage bookkeeping
// Keeps the stage valid bit and merges local stall and squash with downstream

`timescale 1ns/1ps

module stage_ctrl (
  input  logic                       clk,
  input  logic                       reset,
  input  proc_ctrl_pkg::stage_link_t prev,
  input  logic                       stall_self,
  input  logic                       squash_self,
  input  logic                       next_stall,
  input  logic                       next_squash,
  output logic                       reg_en,
  output logic                       val,
  output logic                       next_val,
  output logic                       prev_stall,
  output logic                       prev_squash
);

  logic stall_curr;
  logic squash_curr;

  // A squashed stage never holds the pipe
  assign stall_curr  = val && stall_self && !next_squash;

  // Redirect only on the cycle this stage moves on
  assign squash_curr = val && squash_self && !stall_curr && !next_stall;

  assign reg_en      = !stall_curr && !next_stall;
  assign next_val    = val && !stall_curr && !next_squash;  // Bubble when held or killed
  assign prev_stall  = stall_curr || next_stall;
  assign prev_squash = squash_curr || next_squash;

  always_ff @(posedge clk) begin
    if (reset) begin
      val <= 1'b0;
    end else if (reg_en) begin
      val <= prev.val;
    end
  end

endmodule

// File: hdl/proc_ctrl_pkg.sv
// Pipeline control types
// Select encodings and the bundles passed between stages and to the datapath

`include "proc_ctrl_params.svh"

package proc_ctrl_pkg;

  // Next PC source
  typedef enum logic [1:0] {
    pc_branch = 2'd0,  // Branch target computed in X
    pc_reg    = 2'd1,  // Register value, JR
    pc_jump   = 2'd2,  // Jump target from the immediate
    pc_plus4  = 2'd3
  } pc_sel_e;

  typedef enum logic [1:0] {
    br_none = 2'd0,
    br_eq   = 2'd1,
    br_ne   = 2'd2
  } br_type_e;

  typedef enum logic [1:0] {
    j_none = 2'd0,
    j_imm  = 2'd1,
    j_reg  = 2'd2
  } j_type_e;

  // Operand 1 mux
  typedef enum logic [1:0] {
    op1_rdat     = 2'd0,  // Register file read data
    op1_sext_imm = 2'd1,
    op1_zext_imm = 2'd2
  } op1_sel_e;

  typedef enum logic [2:0] {
    alu_add = 3'd0,
    alu_sub = 3'd1,
    alu_and = 3'd2,
    alu_or  = 3'd3,
    alu_xor = 3'd4,
    alu_lui = 3'd5,  // Immediate into the upper half
    alu_cp1 = 3'd6   // Pass operand 1
  } alu_fn_e;

  typedef enum logic [1:0] {
    mem_none  = 2'd0,
    mem_load  = 2'd1,
    mem_store = 2'd2
  } mem_type_e;

  typedef enum logic {
    wb_alu = 1'b0,
    wb_mem = 1'b1
  } wb_sel_e;

  // Decoded control, carried from D through X, M and W
  typedef struct packed {
    logic                   inst_val;
    br_type_e               br_type;
    j_type_e                j_type;
    alu_fn_e                alu_fn;
    mem_type_e              mem_type;
    wb_sel_e                wb_sel;
    logic                   rf_wen;
    logic [`REG_ADDR_W-1:0] rf_waddr;
  } ctrl_bundle_t;

  // Control to the datapath
  typedef struct packed {
    pc_sel_e                pc_sel_F;
    logic [`NUM_STAGES-1:0] reg_en;     // One enable per stage register
    op1_sel_e               op1_sel_D;
    alu_fn_e                alu_fn_X;
    wb_sel_e                wb_sel_M;
    logic                   rf_wen_W;
    logic [`REG_ADDR_W-1:0] rf_waddr_W;
  } dpath_ctrl_t;

  // Status from the datapath
  typedef struct packed {
    logic [`INST_W-1:0] inst_D;
    logic               br_cond_eq_X;  // Operands equal in X
  } dpath_status_t;

  // Handshake between neighbouring stages
  typedef struct packed {
    logic val;     // Downstream, instruction moving on
    logic stall;   // Upstream, this stage or a later one holds
    logic squash;  // Upstream, a later stage redirects
  } stage_link_t;

endpackage

// File: hdl/proc_ctrl_params.svh
// Pipeline control parameters
// Widths, stage indices, instruction field positions and PISA encodings

`ifndef PROC_CTRL_PARAMS_SVH
`define PROC_CTRL_PARAMS_SVH

`define INST_W      32
`define REG_ADDR_W  5
`define NUM_STAGES  5

// Stage indices into the reg_en and valid vectors
`define STG_F 0
`define STG_D 1
`define STG_X 2
`define STG_M 3
`define STG_W 4

// Instruction fields
`define OP_MSB    31
`define OP_LSB    26
`define RS_MSB    25
`define RS_LSB    21
`define RT_MSB    20
`define RT_LSB    16
`define RD_MSB    15
`define RD_LSB    11
`define FUNC_MSB  5
`define FUNC_LSB  0

// Opcodes
`define OP_SPECIAL  6'b000000  // R-type, decoded by func
`define OP_J        6'b000010
`define OP_BEQ      6'b000100
`define OP_BNE      6'b000101
`define OP_ADDIU    6'b001001
`define OP_ORI      6'b001101
`define OP_LUI      6'b001111
`define OP_LW       6'b100011
`define OP_SW       6'b101011

// Function codes under OP_SPECIAL
`define FUNC_JR     6'b001000
`define FUNC_ADDU   6'b100001
`define FUNC_SUBU   6'b100011
`define FUNC_AND    6'b100100
`define FUNC_OR     6'b100101
`define FUNC_XOR    6'b100110

`endif
